// File: sim.f
design/io_pkg.sv
design/io_decode.sv
design/led_display_regs.sv
design/uart_transmit.sv
design/io_subsystem.sv
tests/tb_clock_gen.sv
tests/io_subsystem_tb.sv

// File: Bender.yml
package:
  name: io_subsystem

sources:
  - design/io_pkg.sv
  - design/io_decode.sv
  - design/led_display_regs.sv
  - design/uart_transmit.sv
  - design/io_subsystem.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/io_subsystem_tb.sv

// File: tests/io_subsystem_tb.sv
// Simulation top that drives io_subsystem with random bus traffic and checks it against models
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_tb;

	localparam int BAUD_DIVIDE = 8;
	localparam int TX_FIFO_DEPTH = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_WRITES = 200;
	localparam int NUM_READS = 60;
	localparam int NUM_STREAM = 30;
	localparam int NUM_BURST = TX_FIFO_DEPTH + 3;
	// Run limit from the test lengths
	localparam int UART_BYTES = NUM_STREAM + NUM_BURST;
	localparam int REG_OPS = NUM_WRITES + NUM_READS + RESET_CYCLES;
	localparam int TIMEOUT_CYCLES = (UART_BYTES * 10 * BAUD_DIVIDE + REG_OPS) * 2;

	logic clk;
	logic reset;
	logic io_write_en;
	logic io_read_en;
	io_pkg::io_addr_t io_address;
	io_pkg::io_data_t io_write_data;
	io_pkg::io_data_t io_read_data;
	logic [io_pkg::RED_LED_BITS-1:0] red_led;
	logic [io_pkg::GREEN_LED_BITS-1:0] green_led;
	io_pkg::seg_t hex0;
	io_pkg::seg_t hex1;
	io_pkg::seg_t hex2;
	io_pkg::seg_t hex3;
	logic uart_tx;

	// Shadow registers and the bytes still owed on the line
	logic [io_pkg::RED_LED_BITS-1:0] model_red;
	logic [io_pkg::GREEN_LED_BITS-1:0] model_green;
	io_pkg::seg_t model_hex[4];
	io_pkg::uart_byte_t expected_bytes[$];

	string test_name;
	int error_count;
	int tests_run;
	int bytes_received;
	int cycle_count;

	tb_clock_gen #(.PERIOD_NS(40)) tb_clock_gen_inst(.clk(clk));

	io_subsystem #(
		.BAUD_DIVIDE(BAUD_DIVIDE),
		.TX_FIFO_DEPTH(TX_FIFO_DEPTH)
	) io_subsystem_inst(
		.clk(clk),
		.reset(reset),
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.uart_tx(uart_tx));

	task automatic report_mismatch(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %s %s expected %h actual %h", test_name, field, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		error_count++;
	endtask

	task automatic finish_test(input int errors_before);
		tests_run++;
		$display("test %s done, %0d errors", test_name, error_count - errors_before);
	endtask

	function automatic io_pkg::io_data_t status_word(input bit ready, input bit idle);
		io_pkg::io_data_t word;
		word = '0;
		word[io_pkg::STATUS_TX_READY] = ready;
		word[io_pkg::STATUS_TX_IDLE] = idle;
		return word;
	endfunction

	// Random word-aligned offset
	// Words 8 to 15 are unmapped
	function automatic io_pkg::io_addr_t pick_offset(input bit skip_uart_data);
		io_pkg::io_addr_t addr;
		addr = io_pkg::io_addr_t'($urandom_range(0, 15) * 4);
		if (skip_uart_data && addr == io_pkg::REG_UART_DATA)
			addr = 16'h0040;
		return addr;
	endfunction

	// Strobe for one cycle, then look at the outputs mid-cycle after the load edge
	task automatic bus_write(input io_pkg::io_addr_t addr, input io_pkg::io_data_t data);
		@(posedge clk);
		io_write_en <= 1'b1;
		io_address <= addr;
		io_write_data <= data;
		@(posedge clk);
		io_write_en <= 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_read(input io_pkg::io_addr_t addr, output io_pkg::io_data_t data);
		@(posedge clk);
		io_read_en <= 1'b1;
		io_address <= addr;
		@(posedge clk);
		io_read_en <= 1'b0;
		@(negedge clk);
		data = io_read_data;
	endtask

	// Mapped writes keep only the low bits that fit
	task automatic update_model(input io_pkg::io_addr_t addr, input io_pkg::io_data_t data);
		case (addr)
			io_pkg::REG_RED_LED: model_red = data[io_pkg::RED_LED_BITS-1:0];
			io_pkg::REG_GREEN_LED: model_green = data[io_pkg::GREEN_LED_BITS-1:0];
			io_pkg::REG_HEX0: model_hex[0] = data[6:0];
			io_pkg::REG_HEX1: model_hex[1] = data[6:0];
			io_pkg::REG_HEX2: model_hex[2] = data[6:0];
			io_pkg::REG_HEX3: model_hex[3] = data[6:0];
			default: ;
		endcase
	endtask

	task automatic compare_display();
		if (red_led !== model_red)
			report_mismatch("red_led", 32'(model_red), 32'(red_led));
		if (green_led !== model_green)
			report_mismatch("green_led", 32'(model_green), 32'(green_led));
		if (hex0 !== model_hex[0])
			report_mismatch("hex0", 32'(model_hex[0]), 32'(hex0));
		if (hex1 !== model_hex[1])
			report_mismatch("hex1", 32'(model_hex[1]), 32'(hex1));
		if (hex2 !== model_hex[2])
			report_mismatch("hex2", 32'(model_hex[2]), 32'(hex2));
		if (hex3 !== model_hex[3])
			report_mismatch("hex3", 32'(model_hex[3]), 32'(hex3));
	endtask

	// Poll until the transmitter drains, then let the last stop bit finish
	task automatic drain_uart();
		io_pkg::io_data_t status;
		status = '0;
		while (status[io_pkg::STATUS_TX_IDLE] !== 1'b1)
			bus_read(io_pkg::REG_UART_STATUS, status);
		repeat (BAUD_DIVIDE) @(negedge clk);
		if (expected_bytes.size() != 0)
			report_failure($sformatf("%0d bytes never came out", expected_bytes.size()));
	endtask

	// Only the first TX_FIFO_DEPTH+1 bytes fit
	// Later ones must be dropped
	task automatic burst_write(input int count);
		io_pkg::io_data_t data;
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			data = $urandom;
			io_write_en <= 1'b1;
			io_address <= io_pkg::REG_UART_DATA;
			io_write_data <= data;
			if (i <= TX_FIFO_DEPTH)
				expected_bytes.push_back(data[7:0]);
		end
		@(posedge clk);
		io_write_en <= 1'b0;
	endtask

	// UART line monitor sampling near the middle of each bit
	initial
	begin
		logic [9:0] frame;
		wait (reset == 1'b0);
		forever
		begin
			@(negedge uart_tx);
			repeat (BAUD_DIVIDE / 2) @(negedge clk);
			frame[0] = uart_tx;
			for (int b = 1; b < 10; b++)
			begin
				repeat (BAUD_DIVIDE) @(negedge clk);
				frame[b] = uart_tx;
			end
			bytes_received++;
			if (frame[0] !== 1'b0)
				report_failure("start bit did not stay low");
			if (frame[9] !== 1'b1)
				report_failure("stop bit was low on the UART line");
			if (expected_bytes.size() == 0)
				report_failure($sformatf("byte %h sent with none expected", frame[8:1]));
			else if (frame[8:1] !== expected_bytes[0])
			begin
				report_mismatch("uart byte", 32'(expected_bytes[0]), 32'(frame[8:1]));
				void'(expected_bytes.pop_front());
			end
			else
				void'(expected_bytes.pop_front());
		end
	end

	// Hard stop if the tests run too long
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing", cycle_count);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		io_pkg::io_addr_t addr;
		io_pkg::io_data_t data;
		io_pkg::io_data_t status;
		io_pkg::io_data_t expected;
		int errors_before;

		reset = 1'b1;
		io_write_en = 1'b0;
		io_read_en = 1'b0;
		io_address = '0;
		io_write_data = '0;
		error_count = 0;
		tests_run = 0;
		bytes_received = 0;
		void'($urandom(32'hf684));

		// Model starts in the reset state
		model_red = '0;
		model_green = '0;
		for (int i = 0; i < 4; i++)
			model_hex[i] = '1;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		test_name = "reset_state";
		errors_before = error_count;
		compare_display();
		if (uart_tx !== 1'b1)
			report_mismatch("uart_tx", 32'h1, 32'(uart_tx));
		if (io_read_data !== '0)
			report_mismatch("io_read_data", 32'h0, io_read_data);
		bus_read(io_pkg::REG_UART_STATUS, status);
		if (status !== status_word(1'b1, 1'b1))
			report_mismatch("status", status_word(1'b1, 1'b1), status);
		finish_test(errors_before);

		test_name = "register_writes";
		errors_before = error_count;
		for (int i = 0; i < NUM_WRITES; i++)
		begin
			addr = pick_offset(1'b1);
			data = $urandom;
			bus_write(addr, data);
			update_model(addr, data);
			compare_display();
		end
		finish_test(errors_before);

		// Transmitter is idle here, so status reads ready and idle
		test_name = "read_return";
		errors_before = error_count;
		for (int i = 0; i < NUM_READS; i++)
		begin
			addr = pick_offset(1'b0);
			bus_read(addr, data);
			expected = (addr == io_pkg::REG_UART_STATUS) ? status_word(1'b1, 1'b1) : '0;
			if (data !== expected)
				report_mismatch($sformatf("read %h", addr), expected, data);
			// Reads leave the display registers alone
			compare_display();
		end
		finish_test(errors_before);

		test_name = "uart_stream";
		errors_before = error_count;
		for (int i = 0; i < NUM_STREAM; i++)
		begin
			status = '0;
			while (status[io_pkg::STATUS_TX_READY] !== 1'b1)
				bus_read(io_pkg::REG_UART_STATUS, status);
			data = $urandom;
			expected_bytes.push_back(data[7:0]);
			bus_write(io_pkg::REG_UART_DATA, data);
		end
		drain_uart();
		finish_test(errors_before);

		test_name = "overflow_drop";
		errors_before = error_count;
		burst_write(NUM_BURST);
		bus_read(io_pkg::REG_UART_STATUS, status);
		if (status[io_pkg::STATUS_TX_READY] !== 1'b0)
			report_mismatch("tx_ready", 32'h0, 32'(status[io_pkg::STATUS_TX_READY]));
		drain_uart();
		finish_test(errors_before);

		$display("tests %0d, uart bytes %0d, errors %0d", tests_run, bytes_received,
			error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Free-running testbench clock source; instantiate once and take clk from its output
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
)(
	output logic clk);

	// Low first, so the first rising edge lands half a period in
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: design/io_subsystem.sv
// Board I/O top: bus decoder, LED/display registers and UART transmitter behind one bus port
`timescale 1ns/1ps
`default_nettype none

module io_subsystem #(
	parameter int BAUD_DIVIDE = 54,
	parameter int TX_FIFO_DEPTH = 8
)(
	input wire logic clk,
	input wire logic reset,
	input wire logic io_write_en,
	input wire logic io_read_en,
	input wire io_pkg::io_addr_t io_address,
	input wire io_pkg::io_data_t io_write_data,
	output io_pkg::io_data_t io_read_data,
	output logic [io_pkg::RED_LED_BITS-1:0] red_led,
	output logic [io_pkg::GREEN_LED_BITS-1:0] green_led,
	output io_pkg::seg_t hex0,
	output io_pkg::seg_t hex1,
	output io_pkg::seg_t hex2,
	output io_pkg::seg_t hex3,
	output logic uart_tx);

	// Decoder to block strobes
	logic [io_pkg::NUM_DISPLAY_REGS-1:0] led_sel;
	logic led_write_en;
	logic uart_write_en;

	// Transmitter back to the read mux
	logic [io_pkg::UART_STATUS_BITS-1:0] uart_status;

	io_decode io_decode_inst(
		.clk(clk),
		.reset(reset),
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_address(io_address),
		.io_read_data(io_read_data),
		.led_sel(led_sel),
		.led_write_en(led_write_en),
		.uart_write_en(uart_write_en),
		.uart_status(uart_status));

	// Write data goes straight from the bus to both blocks
	led_display_regs led_display_regs_inst(
		.clk(clk),
		.reset(reset),
		.led_sel(led_sel),
		.led_write_en(led_write_en),
		.io_write_data(io_write_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3));

	uart_transmit #(
		.BAUD_DIVIDE(BAUD_DIVIDE),
		.TX_FIFO_DEPTH(TX_FIFO_DEPTH)
	) uart_transmit_inst(
		.clk(clk),
		.reset(reset),
		.uart_write_en(uart_write_en),
		.io_write_data(io_write_data),
		.uart_status(uart_status),
		.uart_tx(uart_tx));

endmodule

`default_nettype wire

// File: design/uart_transmit.sv
// UART transmitter with a small FIFO, sending 8N1 frames and reporting ready/idle status
`timescale 1ns/1ps
`default_nettype none

module uart_transmit #(
	parameter int BAUD_DIVIDE = 54,
	parameter int TX_FIFO_DEPTH = 8
)(
	input wire logic clk,
	input wire logic reset,
	input wire logic uart_write_en,
	input wire io_pkg::io_data_t io_write_data,
	output logic [io_pkg::UART_STATUS_BITS-1:0] uart_status,
	output logic uart_tx);

	// Depth is a power of two, pointers wrap on their own
	localparam int PTR_BITS = $clog2(TX_FIFO_DEPTH);
	localparam int COUNT_BITS = $clog2(TX_FIFO_DEPTH + 1);
	localparam int BAUD_BITS = $clog2(BAUD_DIVIDE + 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	io_pkg::uart_byte_t fifo_mem[TX_FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [COUNT_BITS-1:0] fifo_count;
	logic fifo_full;
	logic fifo_empty;
	logic push;
	logic load_frame;

	tx_state_t state;
	logic [BAUD_BITS-1:0] baud_count;
	logic baud_done;
	logic [2:0] bit_count;
	io_pkg::uart_byte_t shifter;

	assign fifo_full = fifo_count == COUNT_BITS'(TX_FIFO_DEPTH);
	assign fifo_empty = fifo_count == '0;

	// Writes into a full FIFO are dropped
	assign push = uart_write_en && !fifo_full;

	assign baud_done = baud_count == BAUD_BITS'(BAUD_DIVIDE - 1);

	// Pull the head byte when idle or right at the end of a stop bit
	assign load_frame = !fifo_empty && (state == TX_IDLE || (state == TX_STOP && baud_done));

	always_ff @(posedge clk)
	begin
		if (push)
			fifo_mem[wr_ptr] <= io_pkg::uart_byte_t'(io_write_data);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;

			if (load_frame)
				rd_ptr <= rd_ptr + 1'b1;

			// Simultaneous push and pop leaves the count alone
			if (push && !load_frame)
				fifo_count <= fifo_count + 1'b1;
			else if (load_frame && !push)
				fifo_count <= fifo_count - 1'b1;
		end
	end

	// Frame FSM, each bit held for BAUD_DIVIDE cycles
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			baud_count <= '0;
			bit_count <= '0;
		end
		else if (load_frame)
		begin
			state <= TX_START;
			baud_count <= '0;
		end
		else if (state != TX_IDLE)
		begin
			if (!baud_done)
				baud_count <= baud_count + 1'b1;
			else
			begin
				baud_count <= '0;
				case (state)
					TX_START:
					begin
						state <= TX_DATA;
						bit_count <= '0;
					end

					TX_DATA:
					begin
						// Eighth bit done, go to stop
						if (bit_count == 3'd7)
							state <= TX_STOP;
						else
							bit_count <= bit_count + 1'b1;
					end

					default:
						state <= TX_IDLE;
				endcase
			end
		end
	end

	// LSB first, shift after each data bit
	always_ff @(posedge clk)
	begin
		if (load_frame)
			shifter <= fifo_mem[rd_ptr];
		else if (state == TX_DATA && baud_done)
			shifter <= shifter >> 1;
	end

	// Line idles high, start bit low
	always_comb
	begin
		case (state)
			TX_START: uart_tx = 1'b0;
			TX_DATA: uart_tx = shifter[0];
			default: uart_tx = 1'b1;
		endcase
	end

	always_comb
	begin
		uart_status = '0;
		uart_status[io_pkg::STATUS_TX_READY] = !fifo_full;
		uart_status[io_pkg::STATUS_TX_IDLE] = state == TX_IDLE && fifo_empty;
	end

endmodule

`default_nettype wire

// File: design/led_display_regs.sv
// Red/green LED and seven-segment digit registers, loaded by bus writes from the decoder
`timescale 1ns/1ps
`default_nettype none

module led_display_regs(
	input wire logic clk,
	input wire logic reset,
	input wire logic [io_pkg::NUM_DISPLAY_REGS-1:0] led_sel,
	input wire logic led_write_en,
	input wire io_pkg::io_data_t io_write_data,
	output logic [io_pkg::RED_LED_BITS-1:0] red_led,
	output logic [io_pkg::GREEN_LED_BITS-1:0] green_led,
	output io_pkg::seg_t hex0,
	output io_pkg::seg_t hex1,
	output io_pkg::seg_t hex2,
	output io_pkg::seg_t hex3);

	// Segments are active low, so all ones is a dark digit
	localparam io_pkg::seg_t SEG_BLANK = '1;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			red_led <= '0;
			green_led <= '0;
			hex0 <= SEG_BLANK;
			hex1 <= SEG_BLANK;
			hex2 <= SEG_BLANK;
			hex3 <= SEG_BLANK;
		end
		else if (led_write_en)
		begin
			// Each register keeps only the low bits that fit
			if (led_sel[io_pkg::SEL_RED_LED])
				red_led <= io_write_data[io_pkg::RED_LED_BITS-1:0];

			if (led_sel[io_pkg::SEL_GREEN_LED])
				green_led <= io_write_data[io_pkg::GREEN_LED_BITS-1:0];

			// Digit patterns, bit 0 is segment a
			if (led_sel[io_pkg::SEL_HEX0])
				hex0 <= io_pkg::seg_t'(io_write_data);

			if (led_sel[io_pkg::SEL_HEX1])
				hex1 <= io_pkg::seg_t'(io_write_data);

			if (led_sel[io_pkg::SEL_HEX2])
				hex2 <= io_pkg::seg_t'(io_write_data);

			if (led_sel[io_pkg::SEL_HEX3])
				hex3 <= io_pkg::seg_t'(io_write_data);
		end
	end

endmodule

`default_nettype wire

// File: design/io_decode.sv
// I/O address decoder: turns bus writes into block strobes and registers read data
`timescale 1ns/1ps
`default_nettype none

module io_decode(
	input wire logic clk,
	input wire logic reset,
	input wire logic io_write_en,
	input wire logic io_read_en,
	input wire io_pkg::io_addr_t io_address,
	output io_pkg::io_data_t io_read_data,
	output logic [io_pkg::NUM_DISPLAY_REGS-1:0] led_sel,
	output logic led_write_en,
	output logic uart_write_en,
	input wire logic [io_pkg::UART_STATUS_BITS-1:0] uart_status);

	logic status_hit;

	// Word compare, byte lane bits ignored
	function automatic logic is_reg(input io_pkg::io_addr_t addr,
		input io_pkg::io_addr_t offset);
		return addr[15:2] == offset[15:2];
	endfunction

	// Select is a pure address decode
	// Gated by the shared enable below
	always_comb
	begin
		led_sel = '0;
		led_sel[io_pkg::SEL_RED_LED] = is_reg(io_address, io_pkg::REG_RED_LED);
		led_sel[io_pkg::SEL_GREEN_LED] = is_reg(io_address, io_pkg::REG_GREEN_LED);
		led_sel[io_pkg::SEL_HEX0] = is_reg(io_address, io_pkg::REG_HEX0);
		led_sel[io_pkg::SEL_HEX1] = is_reg(io_address, io_pkg::REG_HEX1);
		led_sel[io_pkg::SEL_HEX2] = is_reg(io_address, io_pkg::REG_HEX2);
		led_sel[io_pkg::SEL_HEX3] = is_reg(io_address, io_pkg::REG_HEX3);
	end

	// Display block strobe only when some display register matches
	assign led_write_en = io_write_en && (led_sel != '0);

	// Data port of the transmitter
	assign uart_write_en = io_write_en && is_reg(io_address, io_pkg::REG_UART_DATA);

	assign status_hit = is_reg(io_address, io_pkg::REG_UART_STATUS);

	// Read data shows up the cycle after the strobe
	// Holds until the next read
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			io_read_data <= '0;
		else if (io_read_en)
		begin
			// Status is the only readable register
			// Everything else, write-only or unmapped, reads zero
			if (status_hit)
				io_read_data <= io_pkg::io_data_t'(uart_status);
			else
				io_read_data <= '0;
		end
	end

endmodule

`default_nettype wire

// File: design/io_pkg.sv
// Shared I/O bus types, register map and status bit positions for the board I/O RTL
`default_nettype none

package io_pkg;

	// Bus types
	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_data_t;

	// Active-low segment pattern, one digit
	typedef logic [6:0] seg_t;
	typedef logic [7:0] uart_byte_t;

	// Register byte offsets on the I/O bus
	localparam io_addr_t REG_RED_LED = 16'h0000;
	localparam io_addr_t REG_GREEN_LED = 16'h0004;
	localparam io_addr_t REG_HEX0 = 16'h0008;
	localparam io_addr_t REG_HEX1 = 16'h000c;
	localparam io_addr_t REG_HEX2 = 16'h0010;
	localparam io_addr_t REG_HEX3 = 16'h0014;
	localparam io_addr_t REG_UART_STATUS = 16'h0018;
	localparam io_addr_t REG_UART_DATA = 16'h001c;

	// LED register widths
	localparam int RED_LED_BITS = 18;
	localparam int GREEN_LED_BITS = 9;

	// One-hot select positions for the display registers
	localparam int NUM_DISPLAY_REGS = 6;
	localparam int SEL_RED_LED = 0;
	localparam int SEL_GREEN_LED = 1;
	localparam int SEL_HEX0 = 2;
	localparam int SEL_HEX1 = 3;
	localparam int SEL_HEX2 = 4;
	localparam int SEL_HEX3 = 5;

	// UART status word
	localparam int UART_STATUS_BITS = 2;
	localparam int STATUS_TX_READY = 0;
	localparam int STATUS_TX_IDLE = 1;

endpackage

`default_nettype wire
